// File: Makefile
# Verilator simulation of the writeback stage
# override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= wb_cdb_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
	  echo "simulation reported failure, see $(LOG)"; \
	  exit 1; \
	fi
	@if ! grep -q "Result: PASSED" $(LOG); then \
	  echo "simulation ended without a result line, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/long_wb_capture.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// long-latency writeback capture for mcalu0,
// mcalu1 and lsq, held under stall
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module long_wb_capture (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       rob_flush,

  input  logic                       mcalu0_valid,
  input  wb_pkg::wb_entry_t          mcalu0_entry,
  input  logic                       mcalu1_valid,
  input  wb_pkg::wb_entry_t          mcalu1_entry,
  input  logic                       lsq_valid,
  input  wb_pkg::wb_entry_t          lsq_entry,

  // bit 0 mcalu0, bit 1 mcalu1, bit 2 lsq
  input  logic [2:0]                 stall,
  output logic [2:0]                 staged_valid,
  output wb_pkg::wb_entry_t [2:0]    staged_entry
);

  import wb_pkg::*;

  logic [2:0]      lane_valid;
  wb_entry_t [2:0] lane_entry;

  // gather the three sources in lane order
  assign lane_valid    = {lsq_valid, mcalu1_valid, mcalu0_valid};
  assign lane_entry[0] = mcalu0_entry;
  assign lane_entry[1] = mcalu1_entry;
  assign lane_entry[2] = lsq_entry;

  for (genvar i = 0; i < 3; i++) begin : g_lane

    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        staged_valid[i] <= 1'b0;
      end else if (rob_flush) begin
        staged_valid[i] <= 1'b0;
      end else if (!stall[i]) begin
        staged_valid[i] <= lane_valid[i];
      end
    end

    // payload only moves when the lane is free
    always_ff @(posedge clk) begin
      if (!stall[i]) begin
        staged_entry[i] <= lane_entry[i];
      end
    end

    // a stalled result must survive until it wins the bus
    hold_when_stalled: assert property (
      @(posedge clk) disable iff (!arst_n)
      staged_valid[i] && stall[i] && !rob_flush
        |=> staged_valid[i] && $stable(staged_entry[i])
    ) else $error("stalled long-latency lane %0d lost its staged entry", i);

  end

endmodule

// File: design/scalar_wb_capture.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// scalar writeback capture for scalu0 (with CSR)
// and scalu1, held under stall, cleared on flush
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module scalar_wb_capture (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       rob_flush,

  input  logic                       scalu0_valid,
  input  wb_pkg::wb_entry_t          scalu0_entry,
  input  logic                       csr_valid,
  input  wb_pkg::wb_entry_t          csr_entry,
  input  logic                       scalu1_valid,
  input  wb_pkg::wb_entry_t          scalu1_entry,

  // bit 0 scalu0, bit 1 scalu1
  input  logic [1:0]                 stall,
  output logic [1:0]                 staged_valid,
  output wb_pkg::wb_entry_t [1:0]    staged_entry
);

  import wb_pkg::*;

  wb_entry_t s0_next;

  // CSR borrows the scalu0 slot
  assign s0_next = csr_valid ? csr_entry : scalu0_entry;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      staged_valid <= 2'b00;
    end else if (rob_flush) begin
      staged_valid <= 2'b00;
    end else begin
      if (!stall[0]) begin
        staged_valid[0] <= scalu0_valid | csr_valid;
      end
      if (!stall[1]) begin
        staged_valid[1] <= scalu1_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!stall[0]) begin
      staged_entry[0] <= s0_next;
    end
    if (!stall[1]) begin
      staged_entry[1] <= scalu1_entry;
    end
  end

  // CSR only shows up when the scalu0 lane is idle and free
  csr_no_overlap: assert property (
    @(posedge clk) disable iff (!arst_n)
    csr_valid |-> !scalu0_valid
  ) else $error("csr result presented together with a scalu0 result");

  csr_not_stalled: assert property (
    @(posedge clk) disable iff (!arst_n)
    csr_valid |-> !stall[0]
  ) else $error("csr result presented while the scalu0 slot is stalled");

endmodule

// File: design/wb_cdb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// writeback stage, capture banks feeding the
// common data bus selector
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module wb_cdb (
  input  logic               clk,
  input  logic               arst_n,
  input  logic               rob_flush,

  input  logic               scalu0_valid,
  input  wb_pkg::wb_entry_t  scalu0_entry,
  input  logic               scalu1_valid,
  input  wb_pkg::wb_entry_t  scalu1_entry,
  input  logic               mcalu0_valid,
  input  wb_pkg::wb_entry_t  mcalu0_entry,
  input  logic               mcalu1_valid,
  input  wb_pkg::wb_entry_t  mcalu1_entry,
  input  logic               lsq_valid,
  input  wb_pkg::wb_entry_t  lsq_entry,
  input  logic               csr_valid,
  input  wb_pkg::wb_entry_t  csr_entry,

  output logic               scalu0_stall,
  output logic               scalu1_stall,
  output logic               mcalu0_stall,
  output logic               mcalu1_stall,
  output logic               lsq_stall,
  output logic               cdb_valid,
  output wb_pkg::wb_entry_t  cdb_entry
);

  import wb_pkg::*;

  fu_vec_t         staged_valid;
  fu_vec_t         stall;
  wb_entry_t [1:0] scalar_entry;
  wb_entry_t [2:0] long_entry;
  wb_entry_t       staged_entry [num_fu];

  scalar_wb_capture scalar_wb_capture_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .rob_flush    (rob_flush),
    .scalu0_valid (scalu0_valid),
    .scalu0_entry (scalu0_entry),
    .csr_valid    (csr_valid),
    .csr_entry    (csr_entry),
    .scalu1_valid (scalu1_valid),
    .scalu1_entry (scalu1_entry),
    .stall        (stall[fu_scalu1:fu_scalu0]),
    .staged_valid (staged_valid[fu_scalu1:fu_scalu0]),
    .staged_entry (scalar_entry)
  );

  long_wb_capture long_wb_capture_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .rob_flush    (rob_flush),
    .mcalu0_valid (mcalu0_valid),
    .mcalu0_entry (mcalu0_entry),
    .mcalu1_valid (mcalu1_valid),
    .mcalu1_entry (mcalu1_entry),
    .lsq_valid    (lsq_valid),
    .lsq_entry    (lsq_entry),
    .stall        (stall[fu_lsq:fu_mcalu0]),
    .staged_valid (staged_valid[fu_lsq:fu_mcalu0]),
    .staged_entry (long_entry)
  );

  // lay both banks out in lane order
  assign staged_entry[fu_scalu0] = scalar_entry[0];
  assign staged_entry[fu_scalu1] = scalar_entry[1];
  assign staged_entry[fu_mcalu0] = long_entry[0];
  assign staged_entry[fu_mcalu1] = long_entry[1];
  assign staged_entry[fu_lsq]    = long_entry[2];

  wb_cdb_select wb_cdb_select_i (
    .staged_valid (staged_valid),
    .staged_entry (staged_entry),
    .cdb_valid    (cdb_valid),
    .cdb_entry    (cdb_entry),
    .stall        (stall)
  );

  assign scalu0_stall = stall[fu_scalu0];
  assign scalu1_stall = stall[fu_scalu1];
  assign mcalu0_stall = stall[fu_mcalu0];
  assign mcalu1_stall = stall[fu_mcalu1];
  assign lsq_stall    = stall[fu_lsq];

endmodule

// File: design/wb_cdb_select.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fixed-priority common data bus select, stalls
// every staged lane that loses
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module wb_cdb_select (
  input  wb_pkg::fu_vec_t    staged_valid,
  input  wb_pkg::wb_entry_t  staged_entry [wb_pkg::num_fu],
  output logic               cdb_valid,
  output wb_pkg::wb_entry_t  cdb_entry,
  output wb_pkg::fu_vec_t    stall
);

  import wb_pkg::*;

  fu_vec_t grant;

  // lsq first, scalu0 last
  always_comb begin
    grant = '0;
    if (staged_valid[fu_lsq]) begin
      grant[fu_lsq] = 1'b1;
    end else if (staged_valid[fu_mcalu1]) begin
      grant[fu_mcalu1] = 1'b1;
    end else if (staged_valid[fu_mcalu0]) begin
      grant[fu_mcalu0] = 1'b1;
    end else if (staged_valid[fu_scalu1]) begin
      grant[fu_scalu1] = 1'b1;
    end else if (staged_valid[fu_scalu0]) begin
      grant[fu_scalu0] = 1'b1;
    end
  end

  // and-or mux, zero when idle
  always_comb begin
    cdb_entry = '0;
    for (int i = 0; i < num_fu; i++) begin
      if (grant[i]) begin
        cdb_entry = cdb_entry | staged_entry[i];
      end
    end
  end

  assign cdb_valid = |grant;

  // every loser is held in its slot
  assign stall = staged_valid & ~grant;

  // grant sanity, checked against the raw staged vector
  always_comb begin
    if (!$isunknown(staged_valid)) begin
      assert ($onehot0(grant))
        else $error("bus grant is not one-hot: %b", grant);
      assert ((|grant) == (|staged_valid))
        else $error("bus idle while results are staged: %b", staged_valid);
    end
  end

endmodule

// File: design/wb_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// writeback package with payload widths, lane
// indices and the common data bus entry type
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package wb_pkg;

  // result and tag widths
  localparam int xlen     = 32;
  localparam int robid_w  = 7;
  localparam int preg_w   = 6;
  localparam int ecause_w = 5;

  // staged lanes on the bus
  localparam int num_fu = 5;

  // lane positions in a lane vector
  // higher index wins the bus
  localparam int fu_scalu0 = 0;
  localparam int fu_scalu1 = 1;
  localparam int fu_mcalu0 = 2;
  localparam int fu_mcalu1 = 3;
  localparam int fu_lsq    = 4;

  // one writeback, 51 bits
  typedef struct packed {
    logic                error;
    logic [ecause_w-1:0] ecause;
    logic [robid_w-1:0]  robid;
    logic [preg_w-1:0]   rd;
    logic [xlen-1:0]     result;
  } wb_entry_t;

  // one bit per lane
  // staged valids, grants, stalls
  typedef logic [num_fu-1:0] fu_vec_t;

endpackage

// File: sim.f
design/wb_pkg.sv
design/scalar_wb_capture.sv
design/long_wb_capture.sv
design/wb_cdb_select.sv
design/wb_cdb.sv
tb/wb_cdb_tb.sv

// File: tb/wb_cdb_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the writeback stage with random and
// directed traffic checked against a slot model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/10ps

module wb_cdb_tb;

  import wb_pkg::*;

  localparam int random_cycles   = 2000;
  // directed phases plus reset fit well inside this
  localparam int directed_budget = 500;
  localparam int timeout_cycles  = random_cycles + directed_budget;

  logic      clk;
  logic      arst_n;
  logic      rob_flush;
  fu_vec_t   in_valid;
  wb_entry_t in_entry [num_fu];
  logic      csr_valid;
  wb_entry_t csr_entry;

  logic      scalu0_stall;
  logic      scalu1_stall;
  logic      mcalu0_stall;
  logic      mcalu1_stall;
  logic      lsq_stall;
  logic      cdb_valid;
  wb_entry_t cdb_entry;
  fu_vec_t   dut_stall;

  // reference slots for each lane
  fu_vec_t   m_valid;
  wb_entry_t m_entry [num_fu];
  logic      exp_valid;
  wb_entry_t exp_entry;
  fu_vec_t   exp_stall;

  int errors = 0;
  int cycles = 0;

  wb_cdb wb_cdb_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .rob_flush    (rob_flush),
    .scalu0_valid (in_valid[fu_scalu0]),
    .scalu0_entry (in_entry[fu_scalu0]),
    .scalu1_valid (in_valid[fu_scalu1]),
    .scalu1_entry (in_entry[fu_scalu1]),
    .mcalu0_valid (in_valid[fu_mcalu0]),
    .mcalu0_entry (in_entry[fu_mcalu0]),
    .mcalu1_valid (in_valid[fu_mcalu1]),
    .mcalu1_entry (in_entry[fu_mcalu1]),
    .lsq_valid    (in_valid[fu_lsq]),
    .lsq_entry    (in_entry[fu_lsq]),
    .csr_valid    (csr_valid),
    .csr_entry    (csr_entry),
    .scalu0_stall (scalu0_stall),
    .scalu1_stall (scalu1_stall),
    .mcalu0_stall (mcalu0_stall),
    .mcalu1_stall (mcalu1_stall),
    .lsq_stall    (lsq_stall),
    .cdb_valid    (cdb_valid),
    .cdb_entry    (cdb_entry)
  );

  assign dut_stall = {lsq_stall, mcalu1_stall, mcalu0_stall, scalu1_stall, scalu0_stall};

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // highest staged lane or -1 when nothing is staged
  function automatic int top_lane(fu_vec_t v);
    int top;
    top = -1;
    for (int i = 0; i < num_fu; i++) begin
      if (v[i]) begin
        top = i;
      end
    end
    return top;
  endfunction

  function automatic fu_vec_t stall_of(fu_vec_t v);
    int      top;
    fu_vec_t s;
    top = top_lane(v);
    s = v;
    if (top >= 0) begin
      s[top] = 1'b0;
    end
    return s;
  endfunction

  function automatic wb_entry_t rand_entry();
    logic [63:0] raw;
    raw = {$urandom(), $urandom()};
    return raw[$bits(wb_entry_t)-1:0];
  endfunction

  always_comb begin
    exp_valid = (top_lane(m_valid) >= 0);
    exp_stall = stall_of(m_valid);
    exp_entry = '0;
    if (exp_valid) begin
      exp_entry = m_entry[top_lane(m_valid)];
    end
  end

  // advance the slots by one edge with the inputs seen there
  task automatic model_edge();
    fu_vec_t st;
    st = stall_of(m_valid);
    if (rob_flush) begin
      m_valid = '0;
    end else begin
      for (int i = 0; i < num_fu; i++) begin
        if (!st[i]) begin
          m_valid[i] = in_valid[i];
          m_entry[i] = in_entry[i];
        end
      end
      if (!st[fu_scalu0] && csr_valid) begin
        m_valid[fu_scalu0] = 1'b1;
        m_entry[fu_scalu0] = csr_entry;
      end
    end
  endtask

  // one edge and then the inputs for the next cycle
  // stalled lanes keep what they already present
  task automatic step(input fu_vec_t offer, input logic csr, input logic flush);
    fu_vec_t st;
    @(posedge clk);
    model_edge();
    st = stall_of(m_valid);
    for (int i = 0; i < num_fu; i++) begin
      if (!st[i]) begin
        in_valid[i] <= offer[i];
        in_entry[i] <= rand_entry();
      end
    end
    csr_valid <= csr && !offer[fu_scalu0] && !st[fu_scalu0];
    csr_entry <= rand_entry();
    rob_flush <= flush;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      step('0, 1'b0, 1'b0);
    end
  endtask

  cdb_valid_matches: assert property (
    @(posedge clk) disable iff (!arst_n)
    cdb_valid == exp_valid
  ) else begin
    errors++;
    $display("MISMATCH cdb_valid: got %h, expected %h",
             $sampled(cdb_valid), $sampled(exp_valid));
  end

  cdb_entry_matches: assert property (
    @(posedge clk) disable iff (!arst_n)
    cdb_entry == exp_entry
  ) else begin
    errors++;
    $display("MISMATCH cdb_entry: got %h, expected %h",
             $sampled(cdb_entry), $sampled(exp_entry));
  end

  // bit order lsq, mcalu1, mcalu0, scalu1, scalu0
  stall_matches: assert property (
    @(posedge clk) disable iff (!arst_n)
    dut_stall == exp_stall
  ) else begin
    errors++;
    $display("MISMATCH stall: got %h, expected %h",
             $sampled(dut_stall), $sampled(exp_stall));
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("timeout: run still going after %0d cycles", cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    logic [31:0] raw;
    void'($urandom(32'hb1f28022));
    arst_n    = 1'b0;
    rob_flush = 1'b0;
    in_valid  = '0;
    csr_valid = 1'b0;
    csr_entry = '0;
    m_valid   = '0;
    for (int i = 0; i < num_fu; i++) begin
      in_entry[i] = '0;
      m_entry[i]  = '0;
    end
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;

    // quiet bus after reset
    idle(3);

    // each lane alone and then csr alone
    for (int i = 0; i < num_fu; i++) begin
      step(fu_vec_t'(1 << i), 1'b0, 1'b0);
      idle(3);
    end
    step('0, 1'b1, 1'b0);
    idle(3);

    // every lane at once so lsq goes first and the rest wait
    step('1, 1'b0, 1'b0);
    idle(8);
    repeat (6) begin
      step('1, 1'b0, 1'b0);
    end
    idle(8);

    // csr next to a staged mcalu0 result
    step(5'b00100, 1'b1, 1'b0);
    step(5'b01000, 1'b0, 1'b0);
    idle(6);

    // flush with a full set staged and new offers dropped
    step('1, 1'b0, 1'b0);
    step('1, 1'b1, 1'b1);
    idle(4);
    step(5'b10011, 1'b0, 1'b0);
    step('0, 1'b0, 1'b1);
    idle(4);

    repeat (random_cycles) begin
      raw = $urandom();
      step(raw[num_fu-1:0], ($urandom() % 6) == 0, ($urandom() % 64) == 0);
    end
    idle(8);
    @(posedge clk);

    $display("checks done: %0d errors in %0d cycles", errors, cycles);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
